// ==== src/sine_table.svh ====
// One full turn of sine in 32 steps
// Amplitude 74694, leaves room for the 17/16 boost downstream
// Cos is read from the same table, eight entries ahead
// Needs lo_t in scope where included
localparam lo_t sine_table [32] = '{
	// First quadrant
	18'sd0,
	18'sd14572,
	18'sd28584,
	18'sd41498,
	18'sd52817,
	18'sd62106,
	18'sd69008,
	18'sd73259,
	// Second quadrant, peak first
	18'sd74694,
	18'sd73259,
	18'sd69008,
	18'sd62106,
	18'sd52817,
	18'sd41498,
	18'sd28584,
	18'sd14572,
	// Third quadrant
	18'sd0,
	-18'sd14572,
	-18'sd28584,
	-18'sd41498,
	-18'sd52817,
	-18'sd62106,
	-18'sd69008,
	-18'sd73259,
	// Fourth quadrant, negative peak first
	-18'sd74694,
	-18'sd73259,
	-18'sd69008,
	-18'sd62106,
	-18'sd52817,
	-18'sd41498,
	-18'sd28584,
	-18'sd14572
};

// ==== src/rf_types_pkg.sv ====
`default_nettype none

// Data widths shared by the LO and drive path
package rf_types_pkg;

	// ADC input and DAC output sample
	typedef logic signed [15:0] adc_t;

	// LO cos and sin, table amplitude near 74694
	// Headroom left for the 17/16 boost
	typedef logic signed [17:0] lo_t;

	// One I or Q drive component
	typedef logic signed [17:0] drive_t;

	// Coarse phase accumulator
	// Top five bits address the sine table
	typedef logic [19:0] phase_t;

	// Fine phase accumulator and its modulo
	// Fine part wraps at 4096 minus modulo
	typedef logic [11:0] fine_t;

endpackage

`default_nettype wire

// ==== src/rf_timing_pkg.sv ====
`default_nettype none

// Sequencing constants for the LO slice
package rf_timing_pkg;

	// Free-running I/Q divider, wraps through all eight states
	// Bit 0 of the state is the iq flag
	typedef enum logic [2:0] {
		div_s0,
		div_s1,
		div_s2,
		div_s3,
		div_s4,
		div_s5,
		div_s6,
		div_s7
	} div_state_t;

	// Nominal CIC period, IF = clk * 7/33
	localparam int cic_period_default = 33;

	// Divider state ahead of the sync cycle
	// sync goes high the cycle after this state
	localparam div_state_t sync_state = div_s6;

endpackage

`default_nettype wire

// ==== src/lo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// LO bundle between pipeline stages
// Valid every cycle, no back-pressure
interface lo_if import rf_types_pkg::*; ();

	// Quadrature LO pair
	lo_t cos;
	lo_t sin;

	// Divider phase and frame marker
	// Only driven on the conditioned leg
	logic iq;
	logic sync;

	// Producing stage
	modport source (output cos, sin, iq, sync);

	// Consuming stage
	modport sink (input cos, sin, iq, sync);

endinterface

`default_nettype wire

// ==== src/lo_dds.sv ====
`timescale 1ns/1ps
`default_nettype none

// NCO with coarse/fine phase step
// Fine part wraps at a programmable modulo for exact rational IF ratios
module lo_dds import rf_types_pkg::*, rf_timing_pkg::*; #(
	parameter int cic_base_period = cic_period_default
) (
	input wire logic clk,
	input wire logic ctlr_ph_reset,
	input wire logic [31:0] phase_step,
	input wire fine_t modulo,
	input wire logic phase_realign,
	lo_if.source lo
);

	`include "sine_table.svh"

	// Tick counter only needs to reach period-1
	localparam int tick_w = $clog2(cic_base_period);

	// Split of the host phase step
	phase_t step_h;
	fine_t step_l;

	// Accumulator state
	phase_t coarse_acc;
	fine_t fine_acc;

	// Next-state terms
	logic [12:0] fine_sum;
	logic [12:0] fine_wrap;
	logic carry;
	fine_t fine_next;
	phase_t coarse_next;

	// CIC tick and realign request
	logic [tick_w-1:0] tick_cnt;
	logic tick;
	logic realign_req;

	// Table addresses
	logic [4:0] sin_idx;
	logic [4:0] cos_idx;

	assign step_h = phase_step[31:12];
	assign step_l = phase_step[11:0];

	// Two-level accumulate
	always_comb begin
		// One spare bit to catch the fine overflow
		fine_sum = {1'b0, fine_acc} + {1'b0, step_l};
		// Effective fine span, 4096 when modulo is zero
		fine_wrap = 13'd4096 - {1'b0, modulo};
		carry = fine_sum >= fine_wrap;
		fine_next = carry ? fine_t'(fine_sum - fine_wrap) : fine_sum[11:0];
		// Fine carry nudges the coarse phase by one LSB
		coarse_next = coarse_acc + step_h + phase_t'(carry);
	end

	// Fires once per CIC period, on count zero
	assign tick = tick_cnt == '0;

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			tick_cnt <= '0;
			realign_req <= 1'b0;
			coarse_acc <= '0;
			fine_acc <= '0;
		end else begin
			tick_cnt <= (tick_cnt == tick_w'(cic_base_period - 1)) ? '0 : tick_cnt + 1'b1;
			// Request held until a tick consumes it
			// A new pulse on the consuming tick re-arms it
			realign_req <= phase_realign | (realign_req & ~tick);
			if (tick && realign_req) begin
				// Known phase at a known point of the tick cycle
				coarse_acc <= '0;
				fine_acc <= '0;
			end else begin
				coarse_acc <= coarse_next;
				fine_acc <= fine_next;
			end
		end
	end

	// Sin from the top five bits, cos a quarter turn ahead
	assign sin_idx = coarse_acc[19:15];
	assign cos_idx = sin_idx + 5'd8;

	// Registered lookup, one cycle behind the phase
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			lo.cos <= '0;
			lo.sin <= '0;
		end else begin
			lo.cos <= sine_table[cos_idx];
			lo.sin <= sine_table[sin_idx];
		end
	end

endmodule

`default_nettype wire

// ==== src/lo_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

// LO amplitude boost and I/Q state divider
// Net LO amplitude ends near full scale
module lo_conditioner import rf_types_pkg::*, rf_timing_pkg::*; (
	input wire logic clk,
	input wire logic ctlr_ph_reset,
	lo_if.sink raw,
	lo_if.source cond
);

	// Free-running divider state
	div_state_t div_state;

	// Raise by one sixteenth, x + x/16
	// 74694 * 17/16 stays well inside 18 bits
	function automatic lo_t boost(input lo_t v);
		return v + (v >>> 4);
	endfunction

	// Boosted LO, one pipeline stage
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			cond.cos <= '0;
			cond.sin <= '0;
		end else begin
			cond.cos <= boost(raw.cos);
			cond.sin <= boost(raw.sin);
		end
	end

	// Divider steps every clock and wraps at eight
	// sync marks the cycle after the sync state
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			div_state <= div_s0;
			cond.sync <= 1'b0;
		end else begin
			div_state <= div_state_t'(div_state + 3'd1);
			cond.sync <= div_state == sync_state;
		end
	end

	// iq toggles every cycle, starts at zero out of reset
	assign cond.iq = div_state[0];

endmodule

`default_nettype wire

// ==== src/ssb_upconvert.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-sideband upconverter
// dac = round((i*cos - q*sin) / 2^17), saturated
module ssb_upconvert import rf_types_pkg::*; (
	input wire logic clk,
	input wire logic ctlr_ph_reset,
	input wire drive_t drive_i,
	input wire drive_t drive_q,
	lo_if.sink lo,
	output adc_t dac_out
);

	// Full product width
	localparam int prod_w = $bits(drive_t) + $bits(lo_t);
	// Scale back to the DAC range
	localparam int round_shift = 17;
	// Width left after the shift, incl. growth bits
	localparam int shr_w = prod_w + 2 - round_shift;

	// Symmetric clip, -32768 never produced
	localparam adc_t dac_max = 16'sd32767;
	localparam adc_t dac_min = -16'sd32767;

	// Stage 1 products
	logic signed [prod_w-1:0] prod_c;
	logic signed [prod_w-1:0] prod_s;

	// Stage 2 arithmetic
	logic [prod_w:0] diff;
	logic [prod_w+1:0] rounded;
	logic signed [shr_w-1:0] shifted;
	adc_t dac_next;

	// Both multiplies in the same stage
	always_ff @(posedge clk) begin
		prod_c <= drive_i * lo.cos;
		prod_s <= drive_q * lo.sin;
	end

	always_comb begin
		// Sign-extend before subtracting, one growth bit
		diff = {prod_c[prod_w-1], prod_c} - {prod_s[prod_w-1], prod_s};
		// Half an output LSB added, round half up
		rounded = {diff[prod_w], diff} + ((prod_w+2)'(1) << (round_shift - 1));
		shifted = rounded[prod_w+1:round_shift];
		// Full-scale drives overrun the DAC range
		if (shifted > shr_w'(dac_max))
			dac_next = dac_max;
		else if (shifted < shr_w'(dac_min))
			dac_next = dac_min;
		else
			dac_next = shifted[15:0];
	end

	// Output register
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset)
			dac_out <= '0;
		else
			dac_out <= dac_next;
	end

endmodule

`default_nettype wire

// ==== src/rf_drive_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// LO and drive-output slice of the cavity controller
// NCO -> boost/divider -> SSB upconverter, one ADC clock domain
module rf_drive_top import rf_types_pkg::*, rf_timing_pkg::*; #(
	parameter int cic_base_period = cic_period_default
) (
	input wire logic clk,
	input wire logic ctlr_ph_reset,

	// Host-written oscillator controls
	input wire logic [31:0] phase_step,
	input wire fine_t modulo,
	// Single-cycle realign strobe
	input wire logic phase_realign,

	// Baseband drive pair
	input wire drive_t drive_i,
	input wire drive_t drive_q,

	// SSB DAC sample
	output adc_t dac_out,

	// Conditioned LO for other consumers
	output lo_t lo_cos,
	output lo_t lo_sin,
	output logic iq,
	output logic sync
);

	// Raw LO from the NCO
	lo_if raw_lo ();
	// Boosted LO plus divider flags
	lo_if cond_lo ();

	lo_dds #(
		.cic_base_period(cic_base_period)
	) u_dds (
		.clk(clk),
		.ctlr_ph_reset(ctlr_ph_reset),
		.phase_step(phase_step),
		.modulo(modulo),
		.phase_realign(phase_realign),
		.lo(raw_lo.source)
	);

	lo_conditioner u_cond (
		.clk(clk),
		.ctlr_ph_reset(ctlr_ph_reset),
		.raw(raw_lo.sink),
		.cond(cond_lo.source)
	);

	// Accumulator to dac_out is four cycles end to end
	ssb_upconvert u_ssb (
		.clk(clk),
		.ctlr_ph_reset(ctlr_ph_reset),
		.drive_i(drive_i),
		.drive_q(drive_q),
		.lo(cond_lo.sink),
		.dac_out(dac_out)
	);

	// Conditioned LO straight out
	assign lo_cos = cond_lo.cos;
	assign lo_sin = cond_lo.sin;
	assign iq = cond_lo.iq;
	assign sync = cond_lo.sync;

endmodule

`default_nettype wire

// ==== testbench/rf_drive_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// Concurrent checks on the conditioned LO and the DAC output
// lo_side selects which group applies to the bound stage
module rf_drive_chk import rf_types_pkg::*; #(
	parameter bit lo_side = 1'b1
) (
	input wire logic clk,
	input wire logic ctlr_ph_reset,
	input wire lo_t cos,
	input wire lo_t sin,
	input wire logic iq,
	input wire logic sync,
	input wire adc_t dac_out
);

	// Cycles out of reset, stops at 15
	logic [3:0] run_cnt;

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset)
			run_cnt <= '0;
		else if (run_cnt != 4'd15)
			run_cnt <= run_cnt + 4'd1;
	end

	if (lo_side) begin : g_lo
		// Window of eight samples holds exactly one sync
		a_sync_rate: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
			run_cnt == 4'd15 |-> $countones({sync, $past(sync, 1), $past(sync, 2),
				$past(sync, 3), $past(sync, 4), $past(sync, 5), $past(sync, 6),
				$past(sync, 7)}) == 1)
			else $error("sync not once in eight cycles");
		// iq flips on every clock once running
		a_iq_toggle: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
			!$past(ctlr_ph_reset) |-> iq != $past(iq))
			else $error("iq did not toggle");
		// Reset values still showing on the release edge
		a_lo_reset: assert property (@(posedge clk)
			$fell(ctlr_ph_reset) |-> cos == '0 && sin == '0 && !iq && !sync)
			else $error("LO outputs not zero after reset");
	end else begin : g_dac
		// Symmetric clip, never the most negative code
		a_dac_range: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
			dac_out >= -16'sd32767 && dac_out <= 16'sd32767)
			else $error("dac_out outside the clip range");
		a_dac_reset: assert property (@(posedge clk)
			$fell(ctlr_ph_reset) |-> dac_out == '0)
			else $error("dac_out not zero after reset");
	end

endmodule

bind lo_conditioner rf_drive_chk #(.lo_side(1'b1)) u_chk_lo (
	.clk(clk), .ctlr_ph_reset(ctlr_ph_reset), .cos(cond.cos), .sin(cond.sin),
	.iq(cond.iq), .sync(cond.sync), .dac_out('0)
);

bind ssb_upconvert rf_drive_chk #(.lo_side(1'b0)) u_chk_dac (
	.clk(clk), .ctlr_ph_reset(ctlr_ph_reset), .cos(lo.cos), .sin(lo.sin),
	.iq(1'b0), .sync(1'b0), .dac_out(dac_out)
);

`default_nettype wire

// ==== testbench/rf_drive_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the LO and drive-output slice
// Cycle model built from the NCO, boost, divider and SSB rules
module rf_drive_tb import rf_types_pkg::*, rf_timing_pkg::*; ();

	`include "sine_table.svh"

	localparam int n_rows = 8;

	// One stimulus row, held for hold cycles
	typedef struct packed {
		logic [31:0] step;
		fine_t modulo;
		drive_t di;
		drive_t dq;
		logic rand_drive;
		logic realign;
		logic [15:0] hold;
	} row_t;

	// step, modulo, drive_i, drive_q, random drive, realign, hold
	localparam row_t rows [n_rows] = '{
		// Integer coarse step, one table index per cycle
		'{32'h0800_0000, 12'd0, 18'sd40000, 18'sd0, 1'b0, 1'b0, 16'd40},
		// step_h 0x06A0 with a 7/33 fine ratio
		'{32'h006A_0007, 12'd4063, 18'sd30000, -18'sd20000, 1'b0, 1'b0, 16'd70},
		'{32'h0ABC_D123, 12'd0, 18'sd0, 18'sd0, 1'b1, 1'b0, 16'd60},
		// Realign lands on the next tick
		'{32'h0800_0000, 12'd0, 18'sd50000, 18'sd50000, 1'b0, 1'b1, 16'd50},
		'{32'h006A_0007, 12'd4063, -18'sd60000, 18'sd10000, 1'b0, 1'b1, 16'd45},
		// Full scale, 18'sh20000 is the most negative drive
		'{32'h0800_0000, 12'd0, 18'sd131071, 18'sh20000, 1'b0, 1'b0, 16'd40},
		'{32'h0355_5555, 12'd0, 18'sd0, 18'sd0, 1'b1, 1'b1, 16'd80},
		'{32'h0400_0000, 12'd0, 18'sh20000, 18'sd131071, 1'b0, 1'b0, 16'd40}
	};

	logic clk;
	logic ctlr_ph_reset;
	logic [31:0] phase_step;
	fine_t modulo;
	logic phase_realign;
	drive_t drive_i;
	drive_t drive_q;
	adc_t dac_out;
	lo_t lo_cos;
	lo_t lo_sin;
	logic iq;
	logic sync;

	// Model state, one copy per pipeline register
	phase_t m_coarse;
	fine_t m_fine;
	int m_tick;
	logic m_req;
	lo_t m_raw_cos;
	lo_t m_raw_sin;
	lo_t m_cos;
	lo_t m_sin;
	int m_div;
	logic m_sync;
	longint m_prod_c;
	longint m_prod_s;
	adc_t m_dac;

	int errors;
	int cycles;
	int limit;
	logic [31:0] lcg_state = 32'd37;

	rf_drive_top #(
		.cic_base_period(cic_period_default)
	) UUT (
		.clk(clk),
		.ctlr_ph_reset(ctlr_ph_reset),
		.phase_step(phase_step),
		.modulo(modulo),
		.phase_realign(phase_realign),
		.drive_i(drive_i),
		.drive_q(drive_q),
		.dac_out(dac_out),
		.lo_cos(lo_cos),
		.lo_sin(lo_sin),
		.iq(iq),
		.sync(sync)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Value plus a sixteenth of itself
	function automatic lo_t boosted(input lo_t v);
		int x;
		x = int'(v);
		return lo_t'(x + (x >>> 4));
	endfunction

	// Half an LSB in, then floor by 2^17
	function automatic adc_t round_sat(input longint sum);
		longint r;
		r = (sum + 64'sd65536) >>> 17;
		if (r > 32767)
			return 16'sd32767;
		else if (r < -32767)
			return -16'sd32767;
		else
			return adc_t'(r);
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_lo(input string name, input lo_t expected, input lo_t actual);
		if (actual !== expected) begin
			errors++;
			abort_run($sformatf("Fail %s: expected 0x%h, got 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_dac(input adc_t expected, input adc_t actual);
		if (actual !== expected) begin
			errors++;
			abort_run($sformatf("Fail dac_out: expected 0x%h, got 0x%h", expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			abort_run($sformatf("Fail %s: expected 0x%h, got 0x%h", name, expected, actual));
		end
	endtask

	// One clock edge of the model, inputs as seen before the edge
	task automatic step_model();
		int fine_sum;
		int wrap;
		logic carry;
		logic [4:0] sin_idx;
		logic [4:0] cos_idx;
		phase_t coarse_n;
		fine_t fine_n;
		longint pc_n;
		longint ps_n;
		sin_idx = m_coarse[19:15];
		cos_idx = sin_idx + 5'd8;
		// Mixer products have no reset
		pc_n = longint'(drive_i) * longint'(m_cos);
		ps_n = longint'(drive_q) * longint'(m_sin);
		if (ctlr_ph_reset) begin
			m_coarse = '0;
			m_fine = '0;
			m_tick = 0;
			m_req = 1'b0;
			m_raw_cos = '0;
			m_raw_sin = '0;
			m_cos = '0;
			m_sin = '0;
			m_div = 0;
			m_sync = 1'b0;
			m_dac = '0;
		end else begin
			fine_sum = int'(m_fine) + int'(phase_step[11:0]);
			wrap = 4096 - int'(modulo);
			carry = fine_sum >= wrap;
			fine_n = carry ? fine_t'(fine_sum - wrap) : fine_t'(fine_sum);
			coarse_n = m_coarse + phase_step[31:12] + phase_t'(carry);
			// Pending request consumed on count zero
			if (m_tick == 0 && m_req) begin
				coarse_n = '0;
				fine_n = '0;
			end
			m_req = phase_realign || (m_req && m_tick != 0);
			m_tick = (m_tick == cic_period_default - 1) ? 0 : m_tick + 1;
			m_dac = round_sat(m_prod_c - m_prod_s);
			m_sync = m_div == 6;
			m_div = (m_div + 1) % 8;
			m_cos = boosted(m_raw_cos);
			m_sin = boosted(m_raw_sin);
			m_raw_cos = sine_table[cos_idx];
			m_raw_sin = sine_table[sin_idx];
			m_coarse = coarse_n;
			m_fine = fine_n;
		end
		m_prod_c = pc_n;
		m_prod_s = ps_n;
	endtask

	// Outputs settled 1 ns after the edge, inputs move at 2 ns
	always @(posedge clk) begin
		#1;
		step_model();
		check_lo("lo_cos", m_cos, lo_cos);
		check_lo("lo_sin", m_sin, lo_sin);
		check_dac(m_dac, dac_out);
		check_flag("iq", m_div[0], iq);
		check_flag("sync", m_sync, sync);
	end

	task automatic apply_row(input row_t row);
		phase_step = row.step;
		modulo = row.modulo;
		phase_realign = row.realign;
		drive_i = row.di;
		drive_q = row.dq;
		for (int h = 0; h < int'(row.hold); h++) begin
			if (row.rand_drive) begin
				lcg_state = lcg_next(lcg_state);
				drive_i = drive_t'(lcg_state[31:14]);
				lcg_state = lcg_next(lcg_state);
				drive_q = drive_t'(lcg_state[31:14]);
			end
			@(posedge clk);
			#2;
			// Strobe only in the row's first cycle
			phase_realign = 1'b0;
		end
	endtask

	initial begin
		int total;
		total = 0;
		ctlr_ph_reset = 1'b1;
		phase_step = '0;
		modulo = '0;
		phase_realign = 1'b0;
		drive_i = '0;
		drive_q = '0;
		for (int r = 0; r < n_rows; r++)
			total += int'(rows[r].hold);
		limit = total + 100;
		repeat (8) @(posedge clk);
		#2;
		ctlr_ph_reset = 1'b0;
		for (int r = 0; r < n_rows; r++)
			apply_row(rows[r]);
		// Let the last row drain through the pipeline
		repeat (8) @(posedge clk);
		#2;
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		abort_run("Timeout: the run did not finish within the cycle limit");
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/rf_types_pkg.sv
src/rf_timing_pkg.sv
src/lo_if.sv
src/lo_dds.sv
src/lo_conditioner.sv
src/ssb_upconvert.sv
src/rf_drive_top.sv
testbench/rf_drive_chk.sv
testbench/rf_drive_tb.sv

// ==== Makefile ====
# Verilator build and regression for the RF drive slice

SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)

obj_dir/Vrf_drive_tb: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module rf_drive_tb -f all.f

run: obj_dir/Vrf_drive_tb
	@out="$$(./obj_dir/Vrf_drive_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean
